/* hw/npu_consts.svh */
`ifndef NPU_CONSTS_SVH
`define NPU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define NPU_DATA_W      16  // inputs, weights and offsets share one word size
`define NPU_ACC_W       48  // partial sums leave plenty of headroom over 8 products

////////////////////////////////////////////////////////////////////////////
// array size and storage depths
////////////////////////////////////////////////////////////////////////////

`define NPU_NUM_PE      8   // length of the multiply-accumulate chain
`define NPU_WBUF_DEPTH  16  // entries held by each weight ring
`define NPU_OBUF_DEPTH  8   // entries held by the offset ring
`define NPU_AFIFO_DEPTH 8   // partial sums parked between passes

`endif

/* hw/npu_pkg.sv */
`include "npu_consts.svh"

package npu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // scalar types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [`NPU_DATA_W-1:0] npu_data_t;  // one input, weight or offset word
  typedef logic signed [`NPU_ACC_W-1:0] npu_acc_t;  // partial sum flowing down the chain
  typedef logic [$clog2(`NPU_NUM_PE)-1:0] npu_pe_idx_t;  // picks an element or a weight bank

  ////////////////////////////////////////////////////////////////////////////
  // control words
  ////////////////////////////////////////////////////////////////////////////

  // one configuration write, steered either to a weight ring or to the offset ring
  typedef struct packed {
    logic        valid;      // single cycle write strobe
    logic        to_offset;  // high sends data to the offset ring and ignores bank
    npu_pe_idx_t bank;       // weight ring that receives the word
    npu_data_t   data;       // the weight or offset value itself
  } npu_cfg_wr_t;

  // scheduler controls, sampled fresh on every rising edge
  typedef struct packed {
    logic        compute;  // chain advances and weight rings step on this cycle
    logic        pe_wr;    // latch pe_data into the element named by pe_sel
    npu_pe_idx_t pe_sel;   // element whose input register is loaded
    logic        acc_wr;   // push the chain's last partial sum into the FIFO
    logic        acc_rd;   // pop the FIFO head into element 0 instead of an offset
    npu_pe_idx_t out_sel;  // element whose partial sum drives pe_dout
  } npu_sched_t;

endpackage

/* hw/npu_circ_buf.sv */
`timescale 1ns/1ns

module npu_circ_buf #(
  parameter int DEPTH = 16  // number of entries the ring can hold
) (
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               rd_en,   // step to the next written entry
  input  logic               wr_en,   // append din behind the last written entry
  input  npu_pkg::npu_data_t din,
  output npu_pkg::npu_data_t dout   // current entry, shown without a clock edge
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  npu_pkg::npu_data_t mem [DEPTH];  // ring storage, only written entries are ever shown
  logic [PTR_W-1:0] wr_ptr;  // next free slot
  logic [PTR_W-1:0] rd_ptr;  // entry currently on dout
  logic [CNT_W-1:0] count;  // how many entries have been written so far
  logic             empty;
  logic             full;
  logic             rd_last;  // read pointer sits on the newest entry

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign rd_last = ((CNT_W'(rd_ptr) + CNT_W'(1)) == count);

  assign dout = empty ? '0 : mem[rd_ptr];  // an unloaded ring contributes nothing

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en && !full) begin
      mem[wr_ptr] <= din;  // entries stay put once written, the ring only replays them
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      count  <= '0;
    end else if (wr_en && !full) begin
      wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      count  <= count + 1'b1;
    end
  end

  // the read side loops over the written entries only, not the whole depth
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (rd_en && !empty) begin
      rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;  // wrap back to entry 0 after the newest one
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // configuration and compute are separate phases, so a ring never steps while it is loaded
  a_no_rd_with_wr : assert property (@(posedge CLK) disable iff (!arst_n)
    !(rd_en && wr_en))
    else $error("circ_buf: read and write in the same cycle");

  // the configuration stream must fit the ring it targets
  a_no_wr_when_full : assert property (@(posedge CLK) disable iff (!arst_n)
    wr_en |-> !full)
    else $error("circ_buf: write to a full ring dropped");

endmodule

/* hw/npu_proc_eng.sv */
`timescale 1ns/1ns

`include "npu_consts.svh"

module npu_proc_eng (
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               en,       // compute cycle, the partial sum register loads
  input  logic               in_wr,    // this element's slot on the shared input bus
  input  npu_pkg::npu_data_t data_in,  // shared input bus
  input  npu_pkg::npu_data_t weight,   // current entry of this element's weight ring
  input  npu_pkg::npu_acc_t  acc_in,   // partial sum from the previous element or the head
  output npu_pkg::npu_acc_t  acc_out   // registered partial sum for the next element
);

  npu_pkg::npu_data_t              data_q;  // input held across many compute cycles
  logic signed [2*`NPU_DATA_W-1:0] prod;  // full precision product, never truncated
  npu_pkg::npu_acc_t               acc_sum;

  assign prod    = data_q * weight;  // both operands signed, so the product is signed
  assign acc_sum = acc_in + prod;  // prod sign-extends to the partial sum width here

  ////////////////////////////////////////////////////////////////////////////
  // input latch
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      data_q <= '0;  // keeps the product at zero until a real input arrives
    end else if (in_wr) begin
      data_q <= data_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // multiply-accumulate register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      acc_out <= '0;
    end else if (en) begin
      acc_out <= acc_sum;  // one stage of the chain, one cycle per element
    end
  end

endmodule

/* hw/npu_pe_array.sv */
`timescale 1ns/1ns

`include "npu_consts.svh"

module npu_pe_array (
  input  logic               CLK,
  input  logic               arst_n,
  input  npu_pkg::npu_sched_t sched,  // per-cycle scheduler controls
  input  npu_pkg::npu_data_t pe_data,  // input bus shared by all elements
  input  npu_pkg::npu_data_t weights [`NPU_NUM_PE],  // one current weight per element
  input  npu_pkg::npu_data_t offset,  // current bias from the offset ring
  input  npu_pkg::npu_acc_t  fifo_head,  // partial sum parked by an earlier pass
  output npu_pkg::npu_acc_t  chain_out,  // last element's sum, heading for the FIFO
  output npu_pkg::npu_acc_t  pe_dout  // element picked by out_sel
);

  npu_pkg::npu_acc_t        pe_acc [`NPU_NUM_PE];  // registered sum of every element
  npu_pkg::npu_acc_t        pe_cin [`NPU_NUM_PE];  // carry-in seen by every element
  npu_pkg::npu_acc_t        offset_ext;  // bias widened to partial sum width
  npu_pkg::npu_acc_t        carry_in;  // what element 0 adds its product to
  logic [`NPU_NUM_PE-1:0]   in_wr;  // one-hot input latch strobes

  ////////////////////////////////////////////////////////////////////////////
  // element 0 carry-in
  ////////////////////////////////////////////////////////////////////////////

  // offsets are signed, so the top bit is replicated into the upper 32 bits
  assign offset_ext = {{(`NPU_ACC_W - `NPU_DATA_W){offset[`NPU_DATA_W-1]}}, offset};

  // a pop feeds back a stored sum, otherwise a new weighted sum starts from the bias
  assign carry_in = sched.acc_rd ? fifo_head : offset_ext;

  ////////////////////////////////////////////////////////////////////////////
  // input select decode and partial sum chain
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < `NPU_NUM_PE; k++) begin
      in_wr[k] = sched.pe_wr && (sched.pe_sel == npu_pkg::npu_pe_idx_t'(k));  // pe_sel decode
    end
  end

  always_comb begin
    pe_cin[0] = carry_in;
    for (int k = 1; k < `NPU_NUM_PE; k++) begin
      pe_cin[k] = pe_acc[k-1];  // each element extends the sum of the one before it
    end
  end

  for (genvar i = 0; i < `NPU_NUM_PE; i++) begin : g_pe
    npu_proc_eng u_pe (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .en      (sched.compute),  // the whole chain shifts together
      .in_wr   (in_wr[i]),
      .data_in (pe_data),
      .weight  (weights[i]),  // every element has a ring of its own
      .acc_in  (pe_cin[i]),
      .acc_out (pe_acc[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign chain_out = pe_acc[`NPU_NUM_PE-1];  // full weighted sum after the last stage
  assign pe_dout   = pe_acc[sched.out_sel];  // straight from the registers, no extra stage

  // a popped sum only survives if the chain loads it in the same cycle
  a_pop_only_in_compute : assert property (@(posedge CLK) disable iff (!arst_n)
    sched.acc_rd |-> sched.compute)
    else $error("pe_array: FIFO popped outside a compute cycle, sum lost");

endmodule

/* hw/npu_accum_fifo.sv */
`timescale 1ns/1ns

`include "npu_consts.svh"

module npu_accum_fifo (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              wr_en,  // push din at the tail
  input  logic              rd_en,  // drop the head, the next entry shows a cycle later
  input  npu_pkg::npu_acc_t din,  // chain output
  output npu_pkg::npu_acc_t dout  // head, visible before the pop
);

  localparam int DEPTH = `NPU_AFIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  npu_pkg::npu_acc_t mem [DEPTH];  // parked partial sums
  logic [PTR_W-1:0]  wr_ptr;  // tail slot
  logic [PTR_W-1:0]  rd_ptr;  // head slot
  logic [CNT_W-1:0]  count;  // occupancy
  logic              empty;
  logic              full;
  logic              push;  // accepted write
  logic              pop;  // accepted read

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign push  = wr_en && (!full || rd_en);  // a full FIFO still takes a push while it pops
  assign pop   = rd_en && !empty;

  assign dout = empty ? '0 : mem[rd_ptr];  // show-ahead head

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointer wraps by itself
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave occupancy unchanged
      endcase
    end
  end

  // there is no back-pressure, the scheduler alone keeps the FIFO in range
  a_no_overflow : assert property (@(posedge CLK) disable iff (!arst_n)
    (wr_en && full) |-> rd_en)
    else $error("accum_fifo: push to a full FIFO");

  a_no_underflow : assert property (@(posedge CLK) disable iff (!arst_n)
    rd_en |-> !empty)
    else $error("accum_fifo: pop from an empty FIFO");

endmodule

/* hw/npu_compute_unit.sv */
`timescale 1ns/1ns

`include "npu_consts.svh"

module npu_compute_unit (
  input  logic                CLK,
  input  logic                arst_n,
  input  npu_pkg::npu_cfg_wr_t cfg,  // configuration write port
  input  npu_pkg::npu_sched_t sched,  // scheduler controls
  input  npu_pkg::npu_data_t  pe_data,  // input bus towards the element latches
  output npu_pkg::npu_acc_t   pe_dout  // selected element's partial sum
);

  logic [`NPU_NUM_PE-1:0] wbuf_wr;  // one write strobe per weight ring
  logic                   obuf_wr;  // offset ring write strobe
  logic                   obuf_rd;  // offset ring step
  npu_pkg::npu_data_t     wbuf_dout [`NPU_NUM_PE];  // current weight of each ring
  npu_pkg::npu_data_t     obuf_dout;  // current bias
  npu_pkg::npu_acc_t      fifo_head;  // parked partial sum at the FIFO head
  npu_pkg::npu_acc_t      chain_out;  // full weighted sum leaving the chain

  ////////////////////////////////////////////////////////////////////////////
  // configuration write decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < `NPU_NUM_PE; k++) begin
      wbuf_wr[k] = cfg.valid && !cfg.to_offset && (cfg.bank == npu_pkg::npu_pe_idx_t'(k));
    end
  end

  assign obuf_wr = cfg.valid && cfg.to_offset;  // bank is a don't care for offsets

  // a feedback pass reuses the stored sum, so the bias must stay for the next fresh pass
  assign obuf_rd = sched.compute && !sched.acc_rd;

  ////////////////////////////////////////////////////////////////////////////
  // weight and offset rings
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `NPU_NUM_PE; i++) begin : g_wbuf
    npu_circ_buf #(
      .DEPTH (`NPU_WBUF_DEPTH)
    ) u_wbuf (
      .CLK    (CLK),
      .arst_n (arst_n),
      .rd_en  (sched.compute),  // every compute cycle consumes one weight per element
      .wr_en  (wbuf_wr[i]),
      .din    (cfg.data),
      .dout   (wbuf_dout[i])
    );
  end

  npu_circ_buf #(
    .DEPTH (`NPU_OBUF_DEPTH)
  ) u_obuf (
    .CLK    (CLK),
    .arst_n (arst_n),
    .rd_en  (obuf_rd),
    .wr_en  (obuf_wr),
    .din    (cfg.data),
    .dout   (obuf_dout)
  );

  ////////////////////////////////////////////////////////////////////////////
  // element chain and accumulator FIFO
  ////////////////////////////////////////////////////////////////////////////

  npu_pe_array u_pe_array (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .sched     (sched),
    .pe_data   (pe_data),
    .weights   (wbuf_dout),
    .offset    (obuf_dout),
    .fifo_head (fifo_head),
    .chain_out (chain_out),
    .pe_dout   (pe_dout)
  );

  npu_accum_fifo u_accum_fifo (
    .CLK    (CLK),
    .arst_n (arst_n),
    .wr_en  (sched.acc_wr),
    .rd_en  (sched.acc_rd),  // pops in the same cycle element 0 consumes the head
    .din    (chain_out),
    .dout   (fifo_head)
  );

endmodule

/* tb/npu_compute_unit_tb.sv */
`timescale 1ns/1ns

`include "npu_consts.svh"

module npu_compute_unit_tb;

  logic                 CLK = 1'b0;
  logic                 arst_n;
  npu_pkg::npu_cfg_wr_t cfg;
  npu_pkg::npu_sched_t  sched;
  npu_pkg::npu_data_t   pe_data;
  npu_pkg::npu_acc_t    pe_dout;

  logic [31:0] rng = 32'hc2de;  // xorshift state, fixed seed
  logic        after_reset = 1'b0;  // high while the fresh-reset sweep runs
  int          err_model = 0;
  int          err_hold = 0;
  int          err_reset = 0;
  int          err_timeout = 0;

  // reference model state, mirrors the rules of rings, chain and FIFO
  npu_pkg::npu_data_t m_wring [`NPU_NUM_PE][$];  // written weights of every ring
  int                 m_wptr [`NPU_NUM_PE];  // replay position of every weight ring
  npu_pkg::npu_data_t m_oring [$];  // written offsets
  int                 m_optr;
  npu_pkg::npu_acc_t  m_fifo [$];  // parked partial sums, head at index 0
  npu_pkg::npu_data_t m_lat [`NPU_NUM_PE];  // latched element inputs
  npu_pkg::npu_acc_t  m_acc [`NPU_NUM_PE];  // expected element registers
  int                 m_steps;  // compute cycles since the last reset
  npu_pkg::npu_acc_t  exp_dout;

  always #20 CLK = ~CLK;  // 40 ns period

  npu_compute_unit uut (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .cfg     (cfg),
    .sched   (sched),
    .pe_data (pe_data),
    .pe_dout (pe_dout)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic npu_pkg::npu_acc_t widen(input npu_pkg::npu_data_t d);
    npu_pkg::npu_acc_t w;
    w = d;  // signed source, so the assignment sign-extends
    return w;
  endfunction

  function automatic npu_pkg::npu_acc_t mac(input npu_pkg::npu_acc_t acc,
                                            input npu_pkg::npu_data_t d,
                                            input npu_pkg::npu_data_t w);
    return acc + widen(d) * widen(w);  // full 48 bit product, the true value fits easily
  endfunction

  function automatic npu_pkg::npu_data_t weight_now(input int k);
    return (m_wring[k].size() == 0) ? '0 : m_wring[k][m_wptr[k]];  // empty ring reads 0
  endfunction

  function automatic npu_pkg::npu_data_t offset_now();
    return (m_oring.size() == 0) ? '0 : m_oring[m_optr];
  endfunction

  always @(posedge CLK or negedge arst_n) begin : ref_model
    npu_pkg::npu_acc_t nxt [`NPU_NUM_PE];
    npu_pkg::npu_acc_t cin;
    if (!arst_n) begin
      for (int k = 0; k < `NPU_NUM_PE; k++) begin
        m_wring[k].delete();
        m_wptr[k] = 0;
        m_lat[k]  = '0;
        m_acc[k]  = '0;
      end
      m_oring.delete();
      m_fifo.delete();
      m_optr  = 0;
      m_steps = 0;
    end else begin
      if (sched.compute) begin
        cin    = sched.acc_rd ? m_fifo[0] : widen(offset_now());  // head or bias into element 0
        nxt[0] = mac(cin, m_lat[0], weight_now(0));
        for (int k = 1; k < `NPU_NUM_PE; k++) begin
          nxt[k] = mac(m_acc[k-1], m_lat[k], weight_now(k));  // old sum of the element before
        end
      end
      if (sched.acc_rd) begin
        void'(m_fifo.pop_front());
      end
      if (sched.acc_wr) begin
        m_fifo.push_back(m_acc[`NPU_NUM_PE-1]);  // chain output before this edge
      end
      if (sched.compute) begin
        m_acc = nxt;
        for (int k = 0; k < `NPU_NUM_PE; k++) begin
          if (m_wring[k].size() != 0) begin
            m_wptr[k] = (m_wptr[k] + 1) % m_wring[k].size();
          end
        end
        if (!sched.acc_rd && m_oring.size() != 0) begin
          m_optr = (m_optr + 1) % m_oring.size();  // a feedback pass keeps the bias
        end
        m_steps++;
      end
      if (sched.pe_wr) begin
        m_lat[sched.pe_sel] = pe_data;  // the chain above used the old latch value
      end
      if (cfg.valid && cfg.to_offset && m_oring.size() < `NPU_OBUF_DEPTH) begin
        m_oring.push_back(cfg.data);
      end else if (cfg.valid && !cfg.to_offset && m_wring[cfg.bank].size() < `NPU_WBUF_DEPTH) begin
        m_wring[cfg.bank].push_back(cfg.data);
      end
    end
  end

  assign exp_dout = m_acc[sched.out_sel];

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_dout_model : assert property (@(posedge CLK) disable iff (!arst_n)
    pe_dout == exp_dout)
    else begin
      err_model++;
      $display("** Error at %0t ns: pe_dout %0d, model %0d, out_sel %0d", $time,
               $sampled(pe_dout), $sampled(exp_dout), $sampled(sched.out_sel));
    end

  // registers only move on compute cycles
  a_hold : assert property (@(posedge CLK) disable iff (!arst_n)
    !sched.compute ##1 $stable(sched.out_sel) |-> $stable(pe_dout))
    else begin
      err_hold++;
      $display("** Error at %0t ns: pe_dout moved to %0d with compute low, out_sel %0d",
               $time, $sampled(pe_dout), $sampled(sched.out_sel));
    end

  a_reset_zero : assert property (@(posedge CLK) disable iff (!arst_n)
    after_reset |-> pe_dout == '0)
    else begin
      err_reset++;
      $display("** Error at %0t ns: pe_dout %0d after reset, out_sel %0d", $time,
               $sampled(pe_dout), $sampled(sched.out_sel));
    end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic npu_pkg::npu_data_t rand_word();
    rng = xorshift32(rng);
    return npu_pkg::npu_data_t'(rng[23:8]);
  endfunction

  // every input changes on the falling edge only
  task automatic step(input npu_pkg::npu_cfg_wr_t c, input npu_pkg::npu_sched_t s,
                      input npu_pkg::npu_data_t d);
    @(negedge CLK);
    cfg     = c;
    sched   = s;
    pe_data = d;
  endtask

  task automatic apply_reset();
    @(negedge CLK);
    arst_n  = 1'b0;
    cfg     = '0;
    sched   = '0;
    pe_data = '0;
    repeat (5) @(negedge CLK);
    arst_n = 1'b1;
  endtask

  task automatic write_cfg(input logic to_off, input npu_pkg::npu_pe_idx_t bank,
                           input npu_pkg::npu_data_t data);
    npu_pkg::npu_cfg_wr_t c;
    c           = '0;
    c.valid     = 1'b1;
    c.to_offset = to_off;
    c.bank      = bank;
    c.data      = data;
    step(c, '0, '0);
  endtask

  task automatic latch_input(input npu_pkg::npu_pe_idx_t sel, input npu_pkg::npu_data_t data);
    npu_pkg::npu_sched_t s;
    s        = '0;
    s.pe_wr  = 1'b1;
    s.pe_sel = sel;
    step('0, s, data);
  endtask

  task automatic compute_cycle(input logic push, input logic pop,
                               input npu_pkg::npu_pe_idx_t sel);
    npu_pkg::npu_sched_t s;
    s         = '0;
    s.compute = 1'b1;
    s.acc_wr  = push;
    s.acc_rd  = pop;
    s.out_sel = sel;
    step('0, s, '0);
  endtask

  // out_sel walks over the elements while the chain fills
  task automatic compute_until(input int target, input int limit);
    int n;
    n = 0;
    while (m_steps < target && n < limit) begin
      compute_cycle(1'b0, 1'b0, npu_pkg::npu_pe_idx_t'(n % `NPU_NUM_PE));
      n++;
    end
    if (m_steps < target) begin
      err_timeout++;
      $display("timeout: chain reached %0d of %0d compute cycles", m_steps, target);
    end
  endtask

  // two idle cycles per element so the hold check sees a steady out_sel
  task automatic hold_sweep();
    npu_pkg::npu_sched_t s;
    for (int k = 0; k < `NPU_NUM_PE; k++) begin
      s         = '0;
      s.out_sel = npu_pkg::npu_pe_idx_t'(k);
      step('0, s, '0);
      step('0, s, '0);
    end
  endtask

  task automatic load_chain(input logic neg);
    npu_pkg::npu_data_t d;
    for (int k = 0; k < `NPU_NUM_PE; k++) begin
      d = rand_word();
      write_cfg(1'b0, npu_pkg::npu_pe_idx_t'(k), (neg && k % 2 == 0) ? (d | 16'h8000) : d);
    end
    for (int k = 0; k < `NPU_NUM_PE; k++) begin
      d = rand_word();
      latch_input(npu_pkg::npu_pe_idx_t'(k), neg ? (d | 16'h8000) : d);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arst_n  = 1'b0;
    cfg     = '0;
    sched   = '0;
    pe_data = '0;
    repeat (5) @(negedge CLK);
    arst_n = 1'b1;

    after_reset = 1'b1;  // every element reads zero straight out of reset
    hold_sweep();
    after_reset = 1'b0;

    // chain sum with one weight per ring and one bias, then a hold sweep
    apply_reset();
    write_cfg(1'b1, '0, rand_word());
    load_chain(1'b0);
    compute_until(2 * `NPU_NUM_PE, 4 * `NPU_NUM_PE);
    hold_sweep();

    // two-entry ring on bank 0, element 0 alternates products
    apply_reset();
    write_cfg(1'b0, 3'd0, rand_word());
    write_cfg(1'b0, 3'd0, rand_word());
    latch_input(3'd0, rand_word());
    repeat (6) compute_cycle(1'b0, 1'b0, 3'd0);

    // feedback through the FIFO, two offsets reveal a wrongly stepped bias
    apply_reset();
    write_cfg(1'b1, '0, rand_word());
    write_cfg(1'b1, '0, rand_word());
    load_chain(1'b0);
    compute_until(`NPU_NUM_PE, 4 * `NPU_NUM_PE);
    compute_cycle(1'b1, 1'b0, 3'd7);
    compute_cycle(1'b1, 1'b0, 3'd7);
    compute_cycle(1'b0, 1'b1, 3'd0);  // head plus element 0 product
    compute_cycle(1'b0, 1'b0, 3'd0);  // a fresh pass picks up the bias the pop left in place
    compute_cycle(1'b0, 1'b1, 3'd0);
    repeat (3) compute_cycle(1'b0, 1'b0, 3'd0);
    hold_sweep();

    // negative inputs, bias and half the weights
    apply_reset();
    write_cfg(1'b1, '0, rand_word() | 16'h8000);
    load_chain(1'b1);
    compute_until(2 * `NPU_NUM_PE, 4 * `NPU_NUM_PE);
    hold_sweep();

    step('0, '0, '0);
    @(negedge CLK);
    $display("errors: model %0d, hold %0d, reset %0d, timeout %0d",
             err_model, err_hold, err_reset, err_timeout);
    if (err_model + err_hold + err_reset + err_timeout == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hw
hw/npu_pkg.sv
hw/npu_circ_buf.sv
hw/npu_proc_eng.sv
hw/npu_pe_array.sv
hw/npu_accum_fifo.sv
hw/npu_compute_unit.sv
tb/npu_compute_unit_tb.sv

/* Bender.yml */
package:
  name: npu_compute_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/npu_pkg.sv
      - hw/npu_circ_buf.sv
      - hw/npu_proc_eng.sv
      - hw/npu_pe_array.sv
      - hw/npu_accum_fifo.sv
      - hw/npu_compute_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/npu_compute_unit_tb.sv
